//--- ic_fetch_align.sv
// Registers the addressed word one clock after a permitted hit
// Valid repeats every cycle while the request stays high and keeps hitting
module ic_fetch_align (
	input  logic           clk,
	input  logic           rst_i,
	input  logic           fetch_req_i,
	input  ic_pkg::addr_t  fetch_adr_i,
	input  logic           hit_i,
	// From the fill controller
	input  logic           retry_ok_i,
	input  ic_pkg::line_t  line_i,
	// Fetch result, all three valid together
	output logic           instr_valid_o,
	output ic_pkg::word_t  instr_o,
	output ic_pkg::fault_t instr_fault_o
);
	import ic_pkg::*;

	logic take;
	word_t sel_word;

	// Hit counts only while the controller is idle and clean
	assign take = fetch_req_i && hit_i && retry_ok_i;

	// Address bit 2 picks the upper word
	assign sel_word = fetch_adr_i[2] ? line_i.data[63:32] : line_i.data[31:0];

	// ======================================================================
	// Output registers
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			instr_valid_o <= 1'b0;
		end else begin
			instr_valid_o <= take;
		end
	end

	// Fault code travels with the word
	always_ff @(posedge clk) begin
		if (take) begin
			instr_o <= sel_word;
			instr_fault_o <= line_i.fault;
		end
	end

endmodule

//--- ic_fill_ctrl.sv
// Serves a latched invalidate before any miss; ROM fills never touch the bus
// Bus fill is a two-beat burst held until ack or err; an error ends it with a trap line
module ic_fill_ctrl #(
	parameter int ROM_LATENCY = 1,
	parameter int WRITE_LATENCY = 3
) (
	input  logic             clk,
	input  logic             rst_i,
	// Fetch side
	input  logic             fetch_req_i,
	input  ic_pkg::addr_t    fetch_adr_i,
	input  logic             hit_i,
	// Invalidate request
	input  logic             inv_i,
	input  ic_pkg::addr_t    inv_adr_i,
	// Store write and invalidate
	output logic             wr_o,
	output ic_pkg::addr_t    wr_adr_o,
	output ic_pkg::line_t    wr_line_o,
	output logic             inv_o,
	output ic_pkg::addr_t    inv_adr_o,
	// Aligner enable
	output logic             retry_ok_o,
	// Bus
	output ic_pkg::bus_req_t bus_o,
	input  logic             ack_i,
	input  logic             err_i,
	input  ic_pkg::word_t    dat_i,
	output ic_pkg::fill_cnt_t fill_cnt_o
);
	import ic_pkg::*;

	// One wait counter shared by ROM_WAIT and WRITE_WAIT
	localparam int CNT_MAX = (ROM_LATENCY > WRITE_LATENCY) ? ROM_LATENCY : WRITE_LATENCY;
	localparam int CNT_BITS = $clog2(CNT_MAX + 2);

	typedef logic [CNT_BITS-1:0] cnt_t;

	// ======================================================================
	// State
	// ======================================================================
	fill_state_t state_q;
	cnt_t cnt_q;
	// High once the first beat is in
	logic beat_q;
	logic inv_pend_q;
	logic wr_q;
	// Strobe follows cyc for the whole burst
	logic cyc_q;
	fill_cnt_t fill_cnt_q;

	// Payload, no reset
	addr_t inv_adr_q;
	addr_t fill_adr_q;
	addr_t bus_adr_q;
	line_t line_q;

	logic start_fill;
	logic rom_done;
	logic beat_done;

	// Miss seen in IDLE with nothing ahead of it
	assign start_fill = (state_q == IDLE) && !inv_pend_q && fetch_req_i && !hit_i;
	// Last ROM_WAIT cycle
	assign rom_done = (state_q == ROM_WAIT) && (cnt_q == cnt_t'(ROM_LATENCY));
	// A beat ends on ack or err while the request is up
	assign beat_done = cyc_q && (ack_i || err_i);

	// ======================================================================
	// Control FSM
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= IDLE;
			cnt_q <= '0;
			beat_q <= 1'b0;
			inv_pend_q <= 1'b0;
			wr_q <= 1'b0;
			cyc_q <= 1'b0;
			fill_cnt_q <= '0;
		end else begin
			// Write strobe is a single-cycle pulse
			wr_q <= 1'b0;

			// Served in IDLE; a fresh pulse re-arms it
			if (state_q == IDLE && inv_pend_q) begin
				inv_pend_q <= 1'b0;
			end
			if (inv_i) begin
				inv_pend_q <= 1'b1;
			end

			case (state_q)
				IDLE: begin
					cnt_q <= '0;
					beat_q <= 1'b0;
					if (start_fill) begin
						if (in_rom(fetch_adr_i)) begin
							state_q <= ROM_WAIT;
						end else begin
							cyc_q <= 1'b1;
							state_q <= BUS_ACK;
						end
					end
				end
				ROM_WAIT: begin
					cnt_q <= cnt_q + 1'b1;
					if (rom_done) begin
						cnt_q <= '0;
						wr_q <= 1'b1;
						state_q <= WRITE_WAIT;
					end
				end
				BUS_ACK: begin
					if (beat_done) begin
						beat_q <= 1'b1;
						// Error on either beat, or the second ack, ends the cycle
						if (err_i || beat_q) begin
							cyc_q <= 1'b0;
							state_q <= FILL_DONE;
						end
					end
				end
				FILL_DONE: begin
					// Faulted fills count too
					wr_q <= 1'b1;
					fill_cnt_q <= fill_cnt_q + 1'b1;
					cnt_q <= '0;
					state_q <= WRITE_WAIT;
				end
				WRITE_WAIT: begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == cnt_t'(WRITE_LATENCY)) begin
						cnt_q <= '0;
						state_q <= IDLE;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// ======================================================================
	// Address and line assembly
	// ======================================================================
	always_ff @(posedge clk) begin
		if (inv_i) begin
			inv_adr_q <= inv_adr_i;
		end

		// Line-aligned miss address, bus starts at word 0
		if (start_fill) begin
			fill_adr_q <= {fetch_adr_i[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
			bus_adr_q <= {fetch_adr_i[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
			line_q.fault <= FAULT_NONE;
		end

		// ROM lines alias on bits 6 to 3
		if (rom_done) begin
			line_q.data <= rom_image[fill_adr_q[6:3]];
		end

		if (state_q == BUS_ACK && beat_done) begin
			if (err_i) begin
				line_q.fault <= FAULT_BUS;
				line_q.data <= {TRAP_WORD, TRAP_WORD};
			end else if (!beat_q) begin
				line_q.data[31:0] <= dat_i;
				// Second beat address shows the cycle after the first ack
				bus_adr_q <= bus_adr_q + addr_t'(4);
			end else begin
				line_q.data[63:32] <= dat_i;
			end
		end
	end

	// ======================================================================
	// Outputs
	// ======================================================================
	assign wr_o = wr_q;
	assign wr_adr_o = fill_adr_q;
	assign wr_line_o = line_q;

	// Invalidate goes straight to the store in its IDLE cycle
	assign inv_o = (state_q == IDLE) && inv_pend_q;
	assign inv_adr_o = inv_adr_q;

	assign retry_ok_o = (state_q == IDLE) && !inv_pend_q;

	assign bus_o.cyc = cyc_q;
	assign bus_o.stb = cyc_q;
	assign bus_o.adr = bus_adr_q;

	assign fill_cnt_o = fill_cnt_q;

endmodule

//--- ic_l1_store.sv
// Direct-mapped, one line per index, lookup is combinational on the fetch address
// Write and invalidate act on the clock edge; write wins on a shared index
module ic_l1_store #(
	parameter int INDEX_BITS = 3
) (
	input  logic          clk,
	input  logic          rst_i,
	// Lookup port
	input  ic_pkg::addr_t lookup_adr_i,
	output logic          hit_o,
	output ic_pkg::line_t line_o,
	// Line write from the fill controller
	input  logic          wr_i,
	input  ic_pkg::addr_t wr_adr_i,
	input  ic_pkg::line_t wr_line_i,
	// Line invalidate
	input  logic          inv_i,
	input  ic_pkg::addr_t inv_adr_i
);
	import ic_pkg::*;

	localparam int LINES = 1 << INDEX_BITS;
	// Whatever is left above index and offset
	localparam int TAG_BITS = ADDR_BITS - OFFSET_BITS - INDEX_BITS;

	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [TAG_BITS-1:0] tag_t;

	// ======================================================================
	// Storage
	// ======================================================================
	// Valid bits are control state
	logic [LINES-1:0] valid_q;
	tag_t tag_mem [LINES];
	line_t line_mem [LINES];

	index_t lookup_idx;
	index_t wr_idx;
	index_t inv_idx;
	tag_t lookup_tag;
	tag_t wr_tag;

	// Address split
	assign lookup_idx = lookup_adr_i[OFFSET_BITS +: INDEX_BITS];
	assign lookup_tag = lookup_adr_i[ADDR_BITS-1 -: TAG_BITS];
	assign wr_idx = wr_adr_i[OFFSET_BITS +: INDEX_BITS];
	assign wr_tag = wr_adr_i[ADDR_BITS-1 -: TAG_BITS];
	assign inv_idx = inv_adr_i[OFFSET_BITS +: INDEX_BITS];

	// ======================================================================
	// Valid bits
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else begin
			if (inv_i) begin
				valid_q[inv_idx] <= 1'b0;
			end
			// Later assignment, so a same-index write wins
			if (wr_i) begin
				valid_q[wr_idx] <= 1'b1;
			end
		end
	end

	// Tag and line payload
	always_ff @(posedge clk) begin
		if (wr_i) begin
			tag_mem[wr_idx] <= wr_tag;
			line_mem[wr_idx] <= wr_line_i;
		end
	end

	// ======================================================================
	// Lookup
	// ======================================================================
	// Hit needs a valid entry and a matching tag
	assign hit_o = valid_q[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);

	// Line goes out regardless of hit; consumers qualify it
	assign line_o = line_mem[lookup_idx];

endmodule

//--- ic_pkg.sv
// Assumes 16-bit byte addresses and 8-byte lines of two 32-bit words
// ROM window is the top 4 KiB; its 16 lines alias across the whole window
package ic_pkg;

	// ======================================================================
	// Widths and basic types
	// ======================================================================
	localparam int ADDR_BITS = 16;
	// Byte offset bits inside one line
	localparam int OFFSET_BITS = 3;

	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [31:0] word_t;
	// Word 0 sits in the low half
	typedef logic [63:0] line_data_t;
	typedef logic [1:0] fault_t;
	typedef logic [15:0] fill_cnt_t;

	// Fault codes; 1 and 2 stay reserved
	localparam fault_t FAULT_NONE = 2'd0;
	localparam fault_t FAULT_BUS = 2'd3;

	// What one store entry holds besides valid and tag
	typedef struct packed {
		fault_t fault;
		line_data_t data;
	} line_t;

	// Outbound bus request
	typedef struct packed {
		logic cyc;
		logic stb;
		addr_t adr;
	} bus_req_t;

	// Fill controller states
	typedef enum logic [2:0] {
		IDLE,
		ROM_WAIT,
		BUS_ACK,
		FILL_DONE,
		WRITE_WAIT
	} fill_state_t;

	// ======================================================================
	// Boot ROM and trap pattern
	// ======================================================================
	localparam logic [3:0] ROM_BASE_BITS = 4'hf;

	// Replaces both words of a line that took a bus error
	localparam word_t TRAP_WORD = 32'h0010_0073;

	// Indexed by address bits 6 to 3
	localparam line_data_t rom_image [16] = '{
		64'h0000_0093_0000_0013, 64'h0000_0193_0000_0113,
		64'h0000_0293_0000_0213, 64'h0000_0393_0000_0313,
		64'h0010_0413_00f0_0493, 64'h0020_0513_00e0_0593,
		64'h0030_0613_00d0_0693, 64'h0040_0713_00c0_0793,
		64'h1234_5037_0000_0817, 64'h8765_4137_0000_0897,
		64'h0041_0113_0080_0193, 64'h00c2_0213_0100_0293,
		64'h0000_8067_0040_006f, 64'hffdf_f06f_0000_0013,
		64'hdead_beef_cafe_f00d, 64'h0000_0013_0000_0013
	};

	// True inside the ROM window
	function automatic logic in_rom(addr_t adr);
		return adr[ADDR_BITS-1 -: 4] == ROM_BASE_BITS;
	endfunction

endpackage

//--- ic_top.sv
// Store, fill controller and aligner; no handshake on the fetch side
// Bus side stalls only by holding off ack_i
module ic_top #(
	parameter int INDEX_BITS = 3,
	parameter int ROM_LATENCY = 1,
	parameter int WRITE_LATENCY = 3
) (
	input  logic              clk,
	input  logic              rst_i,
	// Fetch
	input  logic              fetch_req_i,
	input  ic_pkg::addr_t     fetch_adr_i,
	output logic              instr_valid_o,
	output ic_pkg::word_t     instr_o,
	output ic_pkg::fault_t    instr_fault_o,
	// Invalidate
	input  logic              inv_i,
	input  ic_pkg::addr_t     inv_adr_i,
	// Bus
	output ic_pkg::bus_req_t  bus_o,
	input  logic              ack_i,
	input  logic              err_i,
	input  ic_pkg::word_t     dat_i,
	output ic_pkg::fill_cnt_t fill_cnt_o
);
	import ic_pkg::*;

	// Lookup result shared by aligner and controller
	logic hit;
	line_t line;

	// Controller to store
	logic wr;
	addr_t wr_adr;
	line_t wr_line;
	logic inv;
	addr_t inv_adr;

	// Controller to aligner
	logic retry_ok;

	// ======================================================================
	// Instances
	// ======================================================================
	ic_l1_store #(
		.INDEX_BITS(INDEX_BITS)
	) ic_l1_store_inst (
		.clk         (clk),
		.rst_i       (rst_i),
		.lookup_adr_i(fetch_adr_i),
		.hit_o       (hit),
		.line_o      (line),
		.wr_i        (wr),
		.wr_adr_i    (wr_adr),
		.wr_line_i   (wr_line),
		.inv_i       (inv),
		.inv_adr_i   (inv_adr)
	);

	ic_fill_ctrl #(
		.ROM_LATENCY  (ROM_LATENCY),
		.WRITE_LATENCY(WRITE_LATENCY)
	) ic_fill_ctrl_inst (
		.clk        (clk),
		.rst_i      (rst_i),
		.fetch_req_i(fetch_req_i),
		.fetch_adr_i(fetch_adr_i),
		.hit_i      (hit),
		.inv_i      (inv_i),
		.inv_adr_i  (inv_adr_i),
		.wr_o       (wr),
		.wr_adr_o   (wr_adr),
		.wr_line_o  (wr_line),
		.inv_o      (inv),
		.inv_adr_o  (inv_adr),
		.retry_ok_o (retry_ok),
		.bus_o      (bus_o),
		.ack_i      (ack_i),
		.err_i      (err_i),
		.dat_i      (dat_i),
		.fill_cnt_o (fill_cnt_o)
	);

	ic_fetch_align ic_fetch_align_inst (
		.clk          (clk),
		.rst_i        (rst_i),
		.fetch_req_i  (fetch_req_i),
		.fetch_adr_i  (fetch_adr_i),
		.hit_i        (hit),
		.retry_ok_i   (retry_ok),
		.line_i       (line),
		.instr_valid_o(instr_valid_o),
		.instr_o      (instr_o),
		.instr_fault_o(instr_fault_o)
	);

endmodule

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_ic_top -o tb_ic_sim

out=$(./obj_dir/tb_ic_sim)
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1

//--- tb.f
+incdir+.
ic_pkg.sv
ic_l1_store.sv
ic_fill_ctrl.sv
ic_fetch_align.sv
ic_top.sv
tb_ic_top.sv

//--- tb_ic_model.svh
// Reference model, included inside the testbench module body
// Backing memory covers 0x0000 to 0x00ff only; stimulus stays in there or the ROM window
`ifndef TB_IC_MODEL_SVH
`define TB_IC_MODEL_SVH

	localparam int MODEL_LINES = 1 << TB_INDEX_BITS;

	// One random word per word address, and the words that answer with an error
	word_t mem_word [64];
	logic err_word [64];

	// Expected L1 contents and bus fill count
	logic exp_valid [MODEL_LINES];
	addr_t exp_tag [MODEL_LINES];
	fill_cnt_t exp_fills;

	function automatic logic is_rom_adr(input addr_t a);
		return a[15:12] == 4'hf;
	endfunction

	// Error on either word spoils the whole line
	function automatic logic line_faults(input addr_t a);
		return err_word[{a[7:3], 1'b0}] || err_word[{a[7:3], 1'b1}];
	endfunction

	function automatic word_t exp_word(input addr_t a);
		line_data_t d;
		if (is_rom_adr(a)) begin
			d = rom_image[a[6:3]];
			return a[2] ? d[63:32] : d[31:0];
		end
		if (line_faults(a)) begin
			return TRAP_WORD;
		end
		return mem_word[a[7:2]];
	endfunction

	function automatic fault_t exp_fault(input addr_t a);
		if (!is_rom_adr(a) && line_faults(a)) begin
			return 2'd3;
		end
		return 2'd0;
	endfunction

	task automatic model_reset();
		for (int i = 0; i < MODEL_LINES; i++) begin
			exp_valid[i] = 1'b0;
			exp_tag[i] = '0;
		end
		exp_fills = '0;
	endtask

	task automatic model_init();
		logic [31:0] v;
		for (int i = 0; i < 64; i++) begin
			draw(stim_lfsr, 32, v);
			mem_word[i] = v;
			err_word[i] = 1'b0;
		end
		// A handful of random faulting words
		for (int i = 0; i < 4; i++) begin
			draw(stim_lfsr, 6, v);
			err_word[v[5:0]] = 1'b1;
		end
		// Line 0x0000 stays clean, line 0x0088 errors on its second beat
		err_word[0] = 1'b0;
		err_word[1] = 1'b0;
		err_word[6'h22] = 1'b0;
		err_word[6'h23] = 1'b1;
		model_reset();
	endtask

	// Miss allocates the line; only bus fills count
	task automatic model_fetch(input addr_t a);
		int idx;
		addr_t tag;
		idx = int'(a[OFFSET_BITS +: TB_INDEX_BITS]);
		tag = a >> (OFFSET_BITS + TB_INDEX_BITS);
		if (!(exp_valid[idx] && exp_tag[idx] == tag)) begin
			exp_valid[idx] = 1'b1;
			exp_tag[idx] = tag;
			if (!is_rom_adr(a)) begin
				exp_fills = exp_fills + 16'd1;
			end
		end
	endtask

	task automatic model_inv(input addr_t a);
		exp_valid[int'(a[OFFSET_BITS +: TB_INDEX_BITS])] = 1'b0;
	endtask

`endif

//--- tb_ic_top.sv
// Drives ic_top with its default parameters; the model assumes INDEX_BITS of 3
// Fetches go one at a time and wait for instr_valid_o; bus acks come after random waits
module tb_ic_top;
	import ic_pkg::*;

	localparam int TB_INDEX_BITS = 3;
	localparam int TB_ROM_LATENCY = 1;
	localparam int TB_WRITE_LATENCY = 3;
	localparam logic [31:0] SEED = 32'hd98e_7b91;
	localparam int RAND_OPS = 240;
	// Two beats of up to 4 cycles, FILL_DONE, WRITE_WAIT, an invalidate and slack
	localparam int WORST_FILL = 24;
	// Directed requests stay well under 16
	localparam int RUN_LIMIT = (RAND_OPS + 16) * WORST_FILL + 40;

	logic clk;
	logic rst_i;
	logic fetch_req_i;
	addr_t fetch_adr_i;
	logic instr_valid_o;
	word_t instr_o;
	fault_t instr_fault_o;
	logic inv_i;
	addr_t inv_adr_i;
	bus_req_t bus_o;
	logic ack_i;
	logic err_i;
	word_t dat_i;
	fill_cnt_t fill_cnt_o;

	// Separate streams for stimulus and responder
	logic [31:0] stim_lfsr;
	logic [31:0] resp_lfsr;
	int cycle_cnt = 0;
	int bus_cycles = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_start_errors = 0;
	string test_name;

	ic_top #(
		.INDEX_BITS   (TB_INDEX_BITS),
		.ROM_LATENCY  (TB_ROM_LATENCY),
		.WRITE_LATENCY(TB_WRITE_LATENCY)
	) ic_top_inst (
		.clk          (clk),
		.rst_i        (rst_i),
		.fetch_req_i  (fetch_req_i),
		.fetch_adr_i  (fetch_adr_i),
		.instr_valid_o(instr_valid_o),
		.instr_o      (instr_o),
		.instr_fault_o(instr_fault_o),
		.inv_i        (inv_i),
		.inv_adr_i    (inv_adr_i),
		.bus_o        (bus_o),
		.ack_i        (ack_i),
		.err_i        (err_i),
		.dat_i        (dat_i),
		.fill_cnt_o   (fill_cnt_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ======================================================================
	// Random source
	// ======================================================================
	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit taken, newest bit in the LSB
	task automatic draw(inout logic [31:0] st, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			st = lfsr_next(st);
			v = {v[30:0], st[0]};
		end
	endtask

	`include "tb_ic_model.svh"

	// ======================================================================
	// Checks and bookkeeping
	// ======================================================================
	task automatic check_word(input string what, input word_t exp, input word_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_fault(input string what, input fault_t exp, input fault_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic check_count(input string what, input fill_cnt_t exp, input fill_cnt_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic note_error(input string msg);
		errors++;
		$display("%s: %s", test_name, msg);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_start_errors = errors;
	endtask

	task automatic end_test();
		tests++;
		if (errors == test_start_errors) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d errors", test_name, errors - test_start_errors);
		end
	endtask

	// ======================================================================
	// Fetch and invalidate drivers, entered and left just after a falling edge
	// ======================================================================
	task automatic fetch_check(input addr_t adr, output int lat);
		logic got;
		lat = 0;
		got = 1'b0;
		model_fetch(adr);
		fetch_req_i = 1'b1;
		fetch_adr_i = adr;
		while (!got && lat < WORST_FILL) begin
			@(negedge clk);
			lat++;
			got = instr_valid_o;
		end
		// Dropped before the next edge so the pulse stays single
		fetch_req_i = 1'b0;
		if (got) begin
			check_word($sformatf("word at %h", adr), exp_word(adr), instr_o);
			check_fault($sformatf("fault at %h", adr), exp_fault(adr), instr_fault_o);
		end else begin
			note_error($sformatf("no instr_valid_o pulse for the fetch of %h", adr));
		end
	endtask

	task automatic inv_pulse(input addr_t adr);
		model_inv(adr);
		inv_i = 1'b1;
		inv_adr_i = adr;
		@(negedge clk);
		inv_i = 1'b0;
	endtask

	// ======================================================================
	// Bus responder
	// ======================================================================
	initial begin : bus_responder
		int wait_left;
		logic [31:0] v;
		ack_i = 1'b0;
		err_i = 1'b0;
		dat_i = '0;
		wait_left = -1;
		forever begin
			@(negedge clk);
			ack_i = 1'b0;
			err_i = 1'b0;
			if (bus_o.cyc && bus_o.stb) begin
				// Fresh beat draws 0 to 3 wait cycles
				if (wait_left < 0) begin
					draw(resp_lfsr, 2, v);
					wait_left = int'(v[1:0]);
				end
				if (wait_left == 0) begin
					if (err_word[bus_o.adr[7:2]]) begin
						err_i = 1'b1;
					end else begin
						ack_i = 1'b1;
						dat_i = mem_word[bus_o.adr[7:2]];
					end
					wait_left = -1;
				end else begin
					wait_left--;
				end
			end
		end
	end

	// Cycle limit and bus activity count
	always @(posedge clk) begin
		cycle_cnt++;
		if (bus_o.cyc) begin
			bus_cycles++;
		end
		if (cycle_cnt > RUN_LIMIT) begin
			$display("Run stopped: %0d cycles passed without the tests finishing", cycle_cnt);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ======================================================================
	// Tests
	// ======================================================================
	initial begin : stimulus
		logic [31:0] op;
		logic [31:0] win;
		logic [31:0] low;
		addr_t adr;
		int lat;
		int bus_mark;
		rst_i = 1'b1;
		fetch_req_i = 1'b0;
		fetch_adr_i = '0;
		inv_i = 1'b0;
		inv_adr_i = '0;
		stim_lfsr = SEED;
		model_init();
		resp_lfsr = stim_lfsr;
		repeat (5) @(negedge clk);
		rst_i = 1'b0;

		start_test("reset");
		check_count("fill count", 16'd0, fill_cnt_o);
		if (bus_o.cyc || instr_valid_o) begin
			note_error("bus cycle or instr_valid_o active right after reset");
		end
		end_test();

		// Miss goes to the bus, the refetch hits in one cycle
		start_test("bus_miss_hit");
		bus_mark = bus_cycles;
		fetch_check(16'h0004, lat);
		check_count("fill count", exp_fills, fill_cnt_o);
		if (bus_cycles == bus_mark) begin
			note_error("the miss did not start a bus cycle");
		end
		bus_mark = bus_cycles;
		fetch_check(16'h0004, lat);
		if (lat != 1) begin
			note_error($sformatf("the refetch took %0d cycles instead of 1", lat));
		end
		if (bus_cycles != bus_mark) begin
			note_error("the refetch touched the bus");
		end
		end_test();

		start_test("rom_fill");
		bus_mark = bus_cycles;
		fetch_check(16'hf014, lat);
		check_count("fill count", exp_fills, fill_cnt_o);
		if (bus_cycles != bus_mark) begin
			note_error("the ROM fill raised cyc");
		end
		end_test();

		// First beat acks, second one errors
		start_test("bus_error");
		fetch_check(16'h008c, lat);
		check_count("fill count", exp_fills, fill_cnt_o);
		fetch_check(16'h008c, lat);
		if (lat != 1) begin
			note_error($sformatf("the faulted refetch took %0d cycles instead of 1", lat));
		end
		end_test();

		start_test("invalidate");
		inv_pulse(16'h0000);
		bus_mark = bus_cycles;
		fetch_check(16'h0000, lat);
		check_count("fill count", exp_fills, fill_cnt_o);
		if (bus_cycles == bus_mark) begin
			note_error("the fetch after the invalidate did not go to the bus");
		end
		end_test();

		// Four tags per index, a quarter in the ROM window
		start_test("random_mix");
		for (int i = 0; i < RAND_OPS; i++) begin
			draw(stim_lfsr, 3, op);
			draw(stim_lfsr, 2, win);
			draw(stim_lfsr, 6, low);
			adr = {(win[1:0] == 2'd0) ? 8'hf0 : 8'h00, low[5:0], 2'b00};
			if (op[2:0] == 3'd0) begin
				inv_pulse(adr);
			end else begin
				fetch_check(adr, lat);
			end
		end
		check_count("final fill count", exp_fills, fill_cnt_o);
		end_test();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
